/* design/exPkg.sv */
// Shared types for the execute back end: micro-op codes, register IDs and stage structs
// Referenced by scoped names from every design file

package exPkg;

	// Micro-op command, anything not listed here is unhandled
	typedef enum logic [5:0] {
		NOP     = 6'h00,
		MOV_RM  = 6'h01, // Store, waits on memory only
		MOV_MR  = 6'h02, // 64-bit load
		FMOV_MR = 6'h03, // Float load, widened to double
		MUL3    = 6'h04,
		FPUV4SF = 6'h05,
		OP_IXT  = 6'h06  // Sub-op in opUIxt
	} uCmdE;

	// OP_IXT sub-op
	typedef enum logic [5:0] {
		KEYLD = 6'h0C // Load keyring control register
	} ixtSubE;

	// Float load format, from opUIxt[5:4]
	typedef enum logic [1:0] {
		FMT_SINGLE = 2'b00,
		FMT_HALF   = 2'b01
	} fmtE;

	typedef logic [5:0] gprIdT;
	typedef logic [4:0] crIdT;

	localparam gprIdT GR_ZZR = 6'h3F; // Zero register, no write
	localparam crIdT CR_ZZR = 5'h1F;
	localparam crIdT CR_KRR = 5'h0E; // Keyring register

	typedef struct packed {
		gprIdT id;
		logic [63:0] value;
	} gprDestT;

	typedef struct packed {
		crIdT id;
		logic [63:0] value;
	} crDestT;

	// Where the GPR result comes from
	typedef enum logic [2:0] {
		FWD    = 3'd0, // Keep forwarded destination
		MEM    = 3'd1,
		MEMCVT = 3'd2, // Widened float load
		MUL    = 3'd3,
		FPV    = 3'd4
	} outSelE;

	typedef struct packed {
		outSelE outSel;
		logic doMemOp;
		logic keyLoad;
		logic unhandled;
		fmtE fmt;
	} stageCtrlT;

	// Memory status level, bit 1 set means not ready
	typedef enum logic [1:0] {
		MEM_READY  = 2'b00,
		MEM_READY1 = 2'b01,
		MEM_BUSY   = 2'b10,
		MEM_FAULT  = 2'b11
	} memStatT;

	typedef struct packed {
		logic memFault;
		logic memTimeout;
		logic unhandled;
	} eventT;

endpackage

/* design/exDecode.sv */
// Micro-op decode for the third execute stage
// Turns command, sub-op and flush into the stage control struct

`timescale 1ns/1ps

module exDecode (
	input exPkg::uCmdE opUCmd,
	input logic [5:0] opUIxt,
	input logic flush,
	output exPkg::stageCtrlT ctrl
);

	exPkg::uCmdE opCmd; // Command after flush kill
	exPkg::ixtSubE ixtSub;

	// Flushed ops become NOP so nothing waits or writes
	assign opCmd = flush ? exPkg::NOP : opUCmd;
	assign ixtSub = exPkg::ixtSubE'(opUIxt);

	always_comb begin
		ctrl.outSel = exPkg::FWD; // Forward unless the op says otherwise
		ctrl.doMemOp = 1'b0;
		ctrl.keyLoad = 1'b0;
		ctrl.unhandled = 1'b0;
		ctrl.fmt = exPkg::fmtE'(opUIxt[5:4]); // Only meaningful for FMOV_MR

		case (opCmd)
			exPkg::NOP: begin
			end

			exPkg::MOV_RM: begin
				ctrl.doMemOp = 1'b1; // Store just waits on memory
			end

			exPkg::MOV_MR: begin
				ctrl.doMemOp = 1'b1;
				ctrl.outSel = exPkg::MEM;
			end

			exPkg::FMOV_MR: begin
				ctrl.doMemOp = 1'b1;
				ctrl.outSel = exPkg::MEMCVT; // Widened load data
			end

			exPkg::MUL3: begin
				ctrl.outSel = exPkg::MUL;
			end

			exPkg::FPUV4SF: begin
				ctrl.outSel = exPkg::FPV;
			end

			exPkg::OP_IXT: begin
				// Only the keyring load does anything here
				if (ixtSub == exPkg::KEYLD) begin
					ctrl.keyLoad = 1'b1;
				end
			end

			default: begin
				ctrl.unhandled = 1'b1; // Unknown command, forwards both
			end
		endcase
	end

endmodule

/* design/fpLoadConv.sv */
// Widens single or half precision load data to an IEEE double
// Denormals flush to signed zero; Inf and NaN keep sign and payload

`timescale 1ns/1ps

module fpLoadConv (
	input logic [63:0] memData,
	input exPkg::fmtE fmt,
	output logic [63:0] cvtData
);

	// Single fields
	logic sSign;
	logic [7:0] sExp;
	logic [22:0] sMant;
	logic [63:0] sDouble;

	// Half fields
	logic hSign;
	logic [4:0] hExp;
	logic [9:0] hMant;
	logic [63:0] hDouble;

	assign sSign = memData[31];
	assign sExp = memData[30:23];
	assign sMant = memData[22:0];

	assign hSign = memData[15];
	assign hExp = memData[14:10];
	assign hMant = memData[9:0];

	// Single to double
	always_comb begin
		if (sExp == 8'h00) begin
			sDouble = {sSign, 63'h0}; // Zero or denormal
		end else if (sExp == 8'hFF) begin
			sDouble = {sSign, 11'h7FF, sMant, 29'h0}; // Inf / NaN, payload to top
		end else begin
			// Rebias 127 -> 1023
			sDouble = {sSign, {3'b000, sExp} + 11'd896, sMant, 29'h0};
		end
	end

	// Half to double
	always_comb begin
		if (hExp == 5'h00) begin
			hDouble = {hSign, 63'h0};
		end else if (hExp == 5'h1F) begin
			hDouble = {hSign, 11'h7FF, hMant, 42'h0};
		end else begin
			hDouble = {hSign, {6'b000000, hExp} + 11'd1008, hMant, 42'h0}; // 15 -> 1023
		end
	end

	// Formats 10 and 11 fall back to single
	always_comb begin
		case (fmt)
			exPkg::FMT_HALF: cvtData = hDouble;
			default: cvtData = sDouble;
		endcase
	end

endmodule

/* design/exStage3.sv */
// Third execute stage that picks the destination result and drives the memory hold
// Hold timeout after memTimeout consecutive wait cycles; flush squash applied last

`timescale 1ns/1ps

module exStage3 #(
	parameter int unsigned memTimeout = 12
) (
	input logic clock,
	input logic rstN,
	input exPkg::stageCtrlT ctrl,
	input logic flush,
	input exPkg::gprIdT regIdRm,
	input exPkg::gprDestT gprIn,
	input exPkg::crDestT crIn,
	input logic [63:0] mulRes,
	input logic [63:0] fpvRes,
	input logic [65:0] krreRes, // Tag in 65:64
	input logic [63:0] memData,
	input logic [63:0] cvtData,
	input exPkg::memStatT memStatus,
	output exPkg::gprDestT gprOut,
	output exPkg::crDestT crOut,
	output exPkg::eventT events,
	output logic exHold
);

	localparam int unsigned cntW = $clog2(memTimeout + 1);

	logic [cntW-1:0] holdCnt; // Consecutive held cycles
	logic [63:0] selVal;
	logic memWait; // Memory op sees busy
	logic timedOut;

	// Result value mux
	always_comb begin
		case (ctrl.outSel)
			exPkg::MEM: selVal = memData;
			exPkg::MEMCVT: selVal = cvtData;
			exPkg::MUL: selVal = mulRes;
			exPkg::FPV: selVal = fpvRes;
			default: selVal = gprIn.value;
		endcase
	end

	assign memWait = ctrl.doMemOp && (memStatus == exPkg::MEM_BUSY);
	assign timedOut = memWait && (holdCnt == cntW'(memTimeout)); // Give up this cycle

	always_comb begin
		gprOut = gprIn; // Forward by default
		crOut = crIn;
		events = '0;
		exHold = 1'b0;

		if (ctrl.outSel != exPkg::FWD) begin
			gprOut = '{id: regIdRm, value: selVal};
		end

		// Keyring load only when tag says valid
		if (ctrl.keyLoad && krreRes[65:64] == 2'b10) begin
			crOut = '{id: exPkg::CR_KRR, value: krreRes[63:0]};
		end

		if (ctrl.doMemOp && memStatus == exPkg::MEM_FAULT) begin
			gprOut.id = exPkg::GR_ZZR; // Faulted load writes nothing
			events.memFault = 1'b1;
		end

		if (memWait) begin
			exHold = !timedOut;
		end

		if (timedOut) begin
			gprOut.id = exPkg::GR_ZZR;
			events.memTimeout = 1'b1;
		end

		events.unhandled = ctrl.unhandled;

		// Branch flush wins over everything
		if (flush) begin
			gprOut.id = exPkg::GR_ZZR;
			crOut.id = exPkg::CR_ZZR;
			exHold = 1'b0;
			events = '0;
		end
	end

	// Hold counter tops out at memTimeout because the hold drops there
	always_ff @(posedge clock) begin
		if (!rstN) begin
			holdCnt <= '0;
		end else if (exHold) begin
			holdCnt <= holdCnt + 1'b1;
		end else begin
			holdCnt <= '0; // Any non-held cycle clears it
		end
	end

endmodule

/* design/exWriteback.sv */
// Writeback latch after the third execute stage
// Captures destinations and events on non-held edges; strobes drop during a hold

`timescale 1ns/1ps

module exWriteback (
	input logic clock,
	input logic rstN,
	input logic exHold,
	input exPkg::gprDestT gprOut,
	input exPkg::crDestT crOut,
	input exPkg::eventT events,
	output exPkg::gprDestT wbGpr,
	output logic wbGprValid,
	output exPkg::crDestT wbCr,
	output logic wbCrValid,
	output exPkg::eventT wbEvents
);

	// Strobes and event pulses
	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbGprValid <= 1'b0;
			wbCrValid <= 1'b0;
			wbEvents <= '0;
		end else if (exHold) begin
			wbGprValid <= 1'b0; // Nothing retires while held
			wbCrValid <= 1'b0;
			wbEvents <= '0;
		end else begin
			wbGprValid <= (gprOut.id != exPkg::GR_ZZR);
			wbCrValid <= (crOut.id != exPkg::CR_ZZR);
			wbEvents <= events;
		end
	end

	// Payload only moves on a non-held edge
	always_ff @(posedge clock) begin
		if (!exHold) begin
			wbGpr <= gprOut;
			wbCr <= crOut;
		end
	end

endmodule

/* design/exBackEnd.sv */
// Top of the execute back end: decode, float load widening, stage 3 and writeback
// memTimeout is set here and handed to the stage

`timescale 1ns/1ps

module exBackEnd #(
	parameter int unsigned memTimeout = 12
) (
	input logic clock,
	input logic rstN,
	input exPkg::uCmdE opUCmd,
	input logic [5:0] opUIxt,
	input logic flush,
	input exPkg::gprIdT regIdRm,
	input exPkg::gprDestT gprIn,
	input exPkg::crDestT crIn,
	input logic [63:0] mulRes,
	input logic [63:0] fpvRes,
	input logic [65:0] krreRes,
	input logic [63:0] memData,
	input exPkg::memStatT memStatus,
	output logic exHold,
	output exPkg::gprDestT wbGpr,
	output logic wbGprValid,
	output exPkg::crDestT wbCr,
	output logic wbCrValid,
	output exPkg::eventT wbEvents
);

	exPkg::stageCtrlT ctrl;
	logic [63:0] cvtData; // Widened float load
	exPkg::gprDestT gprOut;
	exPkg::crDestT crOut;
	exPkg::eventT events;

	exDecode decode (
		.opUCmd(opUCmd),
		.opUIxt(opUIxt),
		.flush(flush),
		.ctrl(ctrl)
	);

	fpLoadConv loadConv (
		.memData(memData),
		.fmt(ctrl.fmt),
		.cvtData(cvtData)
	);

	exStage3 #(.memTimeout(memTimeout)) stage3 (
		.clock(clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.flush(flush),
		.regIdRm(regIdRm),
		.gprIn(gprIn),
		.crIn(crIn),
		.mulRes(mulRes),
		.fpvRes(fpvRes),
		.krreRes(krreRes),
		.memData(memData),
		.cvtData(cvtData),
		.memStatus(memStatus),
		.gprOut(gprOut),
		.crOut(crOut),
		.events(events),
		.exHold(exHold)
	);

	exWriteback writeback (
		.clock(clock),
		.rstN(rstN),
		.exHold(exHold),
		.gprOut(gprOut),
		.crOut(crOut),
		.events(events),
		.wbGpr(wbGpr),
		.wbGprValid(wbGprValid),
		.wbCr(wbCr),
		.wbCrValid(wbCrValid),
		.wbEvents(wbEvents)
	);

endmodule

/* test/tbExBackEnd.sv */
// Testbench for the execute back end with random micro-ops, memory waits, faults and flushes
// Expected writeback comes from a reference model and is checked after each non-held cycle

`timescale 1ns/1ps

module tbExBackEnd;

	localparam int holdLimit = 12;
	localparam int numOps = 300;
	localparam int cycleLimit = 5 + numOps * (holdLimit + 3) + 100; // Worst case per op plus slack

	// One micro-op with its memory behavior
	typedef struct packed {
		logic [5:0] cmd;
		logic [5:0] ixt;
		logic flush;
		exPkg::gprIdT regIdRm;
		exPkg::gprDestT gprIn;
		exPkg::crDestT crIn;
		logic [63:0] mulRes;
		logic [63:0] fpvRes;
		logic [65:0] krreRes;
		logic [63:0] memData;
		logic [7:0] waits; // Busy cycles before finalStat
		exPkg::memStatT finalStat;
	} opT;

	typedef struct packed {
		exPkg::gprDestT gpr;
		exPkg::crDestT cr;
		exPkg::eventT ev;
	} expectT;

	logic clock;
	logic rstN;
	exPkg::uCmdE opUCmd;
	logic [5:0] opUIxt;
	logic flush;
	exPkg::gprIdT regIdRm;
	exPkg::gprDestT gprIn;
	exPkg::crDestT crIn;
	logic [63:0] mulRes;
	logic [63:0] fpvRes;
	logic [65:0] krreRes;
	logic [63:0] memData;
	exPkg::memStatT memStatus;
	logic exHold;
	exPkg::gprDestT wbGpr;
	logic wbGprValid;
	exPkg::crDestT wbCr;
	logic wbCrValid;
	exPkg::eventT wbEvents;

	int seed;
	int cycleCount = 0;
	int valueErrors = 0;
	int flowErrors = 0; // Hold, strobe and reset problems
	expectT expQ[$];
	int dueQ[$]; // Cycle in which each expected result was committed

	exBackEnd #(.memTimeout(holdLimit)) uut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Watchdog
	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Run stopped after %0d cycles, the DUT never finished the test", cycleCount);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic isMemOp(input logic [5:0] cmd);
		return cmd == exPkg::MOV_RM || cmd == exPkg::MOV_MR || cmd == exPkg::FMOV_MR;
	endfunction

	// IEEE widening with half for fmt 01 and single otherwise
	function automatic logic [63:0] widenFloat(input logic [63:0] data, input logic [1:0] fmt);
		logic sign;
		int expIn;
		int bias;
		int expMax;
		logic [51:0] frac;
		if (fmt == 2'b01) begin
			sign = data[15];
			expIn = data[14:10];
			bias = 15;
			expMax = 31;
			frac = {data[9:0], 42'h0};
		end else begin
			sign = data[31];
			expIn = data[30:23];
			bias = 127;
			expMax = 255;
			frac = {data[22:0], 29'h0};
		end
		if (expIn == 0)
			return {sign, 63'h0}; // Zero or flushed denormal
		if (expIn == expMax)
			return {sign, 11'h7FF, frac}; // Inf or NaN
		return {sign, 11'(expIn - bias + 1023), frac};
	endfunction

	function automatic expectT expectOp(input opT op);
		expectT e;
		exPkg::memStatT stat;
		e.gpr = op.gprIn;
		e.cr = op.crIn;
		e.ev = '0;
		if (op.flush) begin
			e.gpr.id = exPkg::GR_ZZR;
			e.cr.id = exPkg::CR_ZZR;
			return e;
		end
		// Waits past the limit end while still busy
		stat = (isMemOp(op.cmd) && op.waits > holdLimit) ? exPkg::MEM_BUSY : op.finalStat;
		case (op.cmd)
			exPkg::NOP, exPkg::MOV_RM: begin
			end
			exPkg::MOV_MR: e.gpr = '{id: op.regIdRm, value: op.memData};
			exPkg::FMOV_MR:
				e.gpr = '{id: op.regIdRm, value: widenFloat(op.memData, op.ixt[5:4])};
			exPkg::MUL3: e.gpr = '{id: op.regIdRm, value: op.mulRes};
			exPkg::FPUV4SF: e.gpr = '{id: op.regIdRm, value: op.fpvRes};
			exPkg::OP_IXT: begin
				if (op.ixt == exPkg::KEYLD && op.krreRes[65:64] == 2'b10)
					e.cr = '{id: exPkg::CR_KRR, value: op.krreRes[63:0]};
			end
			default: e.ev.unhandled = 1'b1;
		endcase
		if (isMemOp(op.cmd) && stat == exPkg::MEM_FAULT) begin
			e.gpr.id = exPkg::GR_ZZR;
			e.ev.memFault = 1'b1;
		end
		if (isMemOp(op.cmd) && stat == exPkg::MEM_BUSY) begin
			e.gpr.id = exPkg::GR_ZZR; // Timed out
			e.ev.memTimeout = 1'b1;
		end
		return e;
	endfunction

	task automatic makeOp(output opT op);
		int pick;
		int kind;
		logic half;
		logic [31:0] word;
		pick = {$random(seed)} % 10;
		case (pick)
			0: op.cmd = exPkg::NOP;
			1: op.cmd = exPkg::MOV_RM;
			2: op.cmd = exPkg::MOV_MR;
			3, 4: op.cmd = exPkg::FMOV_MR;
			5: op.cmd = exPkg::MUL3;
			6: op.cmd = exPkg::FPUV4SF;
			7, 8: op.cmd = exPkg::OP_IXT;
			default: op.cmd = 6'(7 + {$random(seed)} % 57); // Unknown codes
		endcase
		op.ixt = 6'($random(seed));
		if (op.cmd == exPkg::OP_IXT && $random(seed) & 1)
			op.ixt = exPkg::KEYLD;
		op.flush = ({$random(seed)} % 8) == 0;
		op.regIdRm = 6'($random(seed));
		op.gprIn = '{id: 6'($random(seed)), value: {$random(seed), $random(seed)}};
		op.crIn = '{id: 5'($random(seed)), value: {$random(seed), $random(seed)}};
		op.mulRes = {$random(seed), $random(seed)};
		op.fpvRes = {$random(seed), $random(seed)};
		op.krreRes = {($random(seed) & 1) ? 2'b10 : 2'($random(seed)),
			$random(seed), $random(seed)};
		op.memData = {$random(seed), $random(seed)};
		if (op.cmd == exPkg::FMOV_MR) begin
			half = op.ixt[5:4] == 2'b01;
			kind = {$random(seed)} % 5;
			case (kind)
				0: word = 32'h0;
				1: word = half ? 32'h7C00 : 32'h7F80_0000; // Infinity
				2: word = half ? 32'h7E12 : 32'h7FC0_1234; // NaN with payload
				3: word = half ? 32'h0012 : 32'h0000_1234; // Denormal
				default: word = $random(seed);
			endcase
			if (kind < 4)
				word[half ? 15 : 31] = 1'($random(seed)); // Random sign
			if (half)
				op.memData[15:0] = word[15:0];
			else
				op.memData[31:0] = word;
		end
		op.waits = ($random(seed) & 1) ? 8'(1 + {$random(seed)} % (holdLimit + 4)) : 8'd0;
		case ({$random(seed)} % 6)
			0: op.finalStat = exPkg::MEM_FAULT;
			1: op.finalStat = exPkg::MEM_READY1;
			default: op.finalStat = exPkg::MEM_READY;
		endcase
	endtask

	task automatic driveOp(input opT op);
		opUCmd <= exPkg::uCmdE'(op.cmd);
		opUIxt <= op.ixt;
		flush <= op.flush;
		regIdRm <= op.regIdRm;
		gprIn <= op.gprIn;
		crIn <= op.crIn;
		mulRes <= op.mulRes;
		fpvRes <= op.fpvRes;
		krreRes <= op.krreRes;
		memData <= op.memData;
	endtask

	task automatic checkGpr(input exPkg::gprDestT got, input logic gotValid,
			input exPkg::gprDestT exp);
		logic expValid;
		expValid = exp.id != exPkg::GR_ZZR;
		if (gotValid !== expValid) begin
			$display("CHECK FAILED wbGprValid got %h expected %h at %0t", gotValid, expValid, $time);
			valueErrors++;
		end
		if (got.id !== exp.id || (expValid && got.value !== exp.value)) begin
			$display("CHECK FAILED wbGpr got %h expected %h at %0t", got, exp, $time);
			valueErrors++;
		end
	endtask

	task automatic checkCr(input exPkg::crDestT got, input logic gotValid,
			input exPkg::crDestT exp);
		logic expValid;
		expValid = exp.id != exPkg::CR_ZZR;
		if (gotValid !== expValid) begin
			$display("CHECK FAILED wbCrValid got %h expected %h at %0t", gotValid, expValid, $time);
			valueErrors++;
		end
		if (got.id !== exp.id || (expValid && got.value !== exp.value)) begin
			$display("CHECK FAILED wbCr got %h expected %h at %0t", got, exp, $time);
			valueErrors++;
		end
	endtask

	task automatic checkEvents(input exPkg::eventT got, input exPkg::eventT exp);
		if (got !== exp) begin
			$display("CHECK FAILED wbEvents got %h expected %h at %0t", got, exp, $time);
			valueErrors++;
		end
	endtask

	// Compares one cycle after commit
	initial begin
		expectT e;
		forever begin
			@(negedge clock);
			while (dueQ.size() > 0 && dueQ[0] == cycleCount - 1) begin
				e = expQ.pop_front();
				void'(dueQ.pop_front());
				checkGpr(wbGpr, wbGprValid, e.gpr);
				checkCr(wbCr, wbCrValid, e.cr);
				checkEvents(wbEvents, e.ev);
			end
		end
	end

	// Stimulus and hold tracking
	initial begin
		opT op;
		expectT e;
		int c;
		logic prevHeld;
		logic expHold;
		seed = 32'h4e40;
		rstN = 1'b0;
		opUCmd = exPkg::NOP;
		opUIxt = '0;
		flush = 1'b0;
		regIdRm = exPkg::GR_ZZR;
		gprIn = '{id: exPkg::GR_ZZR, value: 64'h0};
		crIn = '{id: exPkg::CR_ZZR, value: 64'h0};
		mulRes = '0;
		fpvRes = '0;
		krreRes = '0;
		memData = '0;
		memStatus = exPkg::MEM_READY;
		repeat (4) @(posedge clock);
		@(negedge clock);
		if (wbGprValid !== 1'b0 || wbCrValid !== 1'b0 || wbEvents !== '0) begin
			$display("Writeback strobes or events not cleared during reset");
			flowErrors++;
		end
		@(posedge clock);
		rstN <= 1'b1;
		for (int i = 0; i < numOps; i++) begin
			makeOp(op);
			e = expectOp(op);
			@(posedge clock);
			driveOp(op);
			memStatus <= (op.waits > 0) ? exPkg::MEM_BUSY : op.finalStat;
			c = 0;
			prevHeld = 1'b0;
			forever begin
				@(negedge clock);
				expHold = isMemOp(op.cmd) && !op.flush && c < op.waits && c < holdLimit;
				if (exHold !== expHold) begin
					if (expHold)
						$display("Missing hold on op %0d wait cycle %0d at %0t", i, c, $time);
					else
						$display("Unexpected hold on op %0d cycle %0d at %0t", i, c, $time);
					flowErrors++;
				end
				if (prevHeld && (wbGprValid || wbCrValid || wbEvents != '0)) begin
					$display("Writeback strobe or event seen during a hold at %0t", $time);
					flowErrors++;
				end
				if (exHold !== 1'b1)
					break;
				prevHeld = 1'b1;
				c++;
				@(posedge clock);
				memStatus <= (c < op.waits) ? exPkg::MEM_BUSY : op.finalStat;
			end
			expQ.push_back(e); // Commits at the coming edge
			dueQ.push_back(cycleCount);
		end
		repeat (2) @(negedge clock);
		$display("Errors: %0d value, %0d hold/flow over %0d ops", valueErrors, flowErrors, numOps);
		if (valueErrors + flowErrors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* all.f */
design/exPkg.sv
design/exDecode.sv
design/fpLoadConv.sv
design/exStage3.sv
design/exWriteback.sv
design/exBackEnd.sv
test/tbExBackEnd.sv

/* Bender.yml */
package:
  name: ex_back_end

sources:
  - design/exPkg.sv
  - design/exDecode.sv
  - design/fpLoadConv.sv
  - design/exStage3.sv
  - design/exWriteback.sv
  - design/exBackEnd.sv
  - target: test
    files:
      - test/tbExBackEnd.sv
